//--- Makefile
# Verilator flow for the memory test accelerator

TOP := mem_afu_tb

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

# Build and run, a crash or a nonzero exit also counts as a failure
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- src.f
verilog/mem_afu_pkg.sv
verilog/host_port_reg.sv
verilog/mem_test_engine.sv
verilog/mem_bank_router.sv
verilog/mem_bank_model.sv
verilog/mem_afu_top.sv
testbench/mem_afu_tb.sv

//--- testbench/mem_afu_tb.sv
// Memory test accelerator testbench

`timescale 1ns/1ns

module mem_afu_tb;

    localparam int ADDR_WIDTH   = 10;
    localparam int READ_LATENCY = 3;
    localparam int MEM_DEPTH    = 2 ** ADDR_WIDTH;
    localparam int CLK_PERIOD   = 8;
    localparam int POLL_LIMIT   = 40;
    localparam logic [63:0] ADDR_MASK = (64'd1 << ADDR_WIDTH) - 64'd1;

    // Run bound, every test issues at most MAX_CMDS commands and every
    // status poll costs four cycles
    localparam int NUM_TESTS   = 5;
    localparam int MAX_CMDS    = 20;
    localparam int WATCHDOG_NS = NUM_TESTS * MAX_CMDS * POLL_LIMIT * 4 * CLK_PERIOD + 1000;

    logic                   clk;
    logic                   rst;
    mem_afu_pkg::host_req_t host_req;
    mem_afu_pkg::host_rsp_t host_rsp;

    // Expected contents of both banks
    logic [63:0] expected_mem [2][MEM_DEPTH];

    // Completed memory accesses the command counter should show
    int cmds_done;

    int error_count;
    int tests_passed;
    int tests_failed;

    mem_afu_top #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .READ_LATENCY (READ_LATENCY)
    ) mem_afu_top_inst (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // ========================================================================
    // Host access helpers, all entered and left on a falling edge
    // ========================================================================

    task automatic flag_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        $display("FAILED at %0t ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic host_write(input logic [2:0] addr, input logic [63:0] data);
        host_req.wr    = 1'b1;
        host_req.addr  = addr;
        host_req.wdata = data;
        @(negedge clk);
        host_req.wr = 1'b0;
    endtask

    // The response must show up on the third falling edge after the strobe
    task automatic host_read(input logic [2:0] addr, output logic [63:0] data);
        int cycles;
        bit seen;
        cycles        = 0;
        seen          = 1'b0;
        host_req.rd   = 1'b1;
        host_req.addr = addr;
        while (!seen && cycles < 8)
        begin
            @(negedge clk);
            host_req.rd = 1'b0;
            cycles++;
            seen = host_rsp.rd_valid;
        end
        data = host_rsp.rdata;
        if (!seen)
        begin
            $display("Read of register %0d got no response within 8 cycles", addr);
            error_count++;
        end
        else if (cycles != 3)
        begin
            flag_mismatch("host_rsp.rd_valid latency", 64'd3, 64'(cycles));
        end
    endtask

    // Poll the status word until the done bit comes up
    task automatic wait_done();
        int polls;
        bit done;
        logic [63:0] status;
        polls = 0;
        done  = 1'b0;
        while (!done && polls < POLL_LIMIT)
        begin
            host_read(mem_afu_pkg::REG_STATUS, status);
            polls++;
            done = status[mem_afu_pkg::STATUS_DONE_BIT];
        end
        if (!done)
        begin
            $display("Command did not complete within %0d status polls", POLL_LIMIT);
            error_count++;
        end
    endtask

    // Every command run here is a real access and adds one to the count
    task automatic run_cmd(input logic [1:0] opcode);
        host_write(mem_afu_pkg::REG_CMD, 64'(opcode));
        wait_done();
        cmds_done++;
    endtask

    task automatic write_word(input logic bank, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [63:0] data);
        host_write(mem_afu_pkg::REG_BANK, 64'(bank));
        host_write(mem_afu_pkg::REG_ADDR, 64'(addr));
        host_write(mem_afu_pkg::REG_WDATA, data);
        run_cmd(mem_afu_pkg::CMD_WRITE);
        expected_mem[bank][addr] = data;
    endtask

    task automatic read_word(input logic bank, input logic [ADDR_WIDTH-1:0] addr,
                             output logic [63:0] data);
        host_write(mem_afu_pkg::REG_BANK, 64'(bank));
        host_write(mem_afu_pkg::REG_ADDR, 64'(addr));
        run_cmd(mem_afu_pkg::CMD_READ);
        host_read(mem_afu_pkg::REG_RDATA, data);
    endtask

    function automatic logic [ADDR_WIDTH-1:0] random_addr();
        logic [31:0] r;
        r = $urandom();
        return r[ADDR_WIDTH-1:0];
    endfunction

    function automatic logic [63:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $urandom();
        lo = $urandom();
        return {hi, lo};
    endfunction

    task automatic log_result(input string name, input int errors_before);
        if (error_count == errors_before)
        begin
            tests_passed++;
            $display("Test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic register_access();
        int errs;
        logic [63:0] r;
        logic [63:0] got;
        errs = error_count;
        host_read(mem_afu_pkg::REG_STATUS, got);
        if (got !== 64'd0) flag_mismatch("REG_STATUS", 64'd0, got);
        host_read(mem_afu_pkg::REG_COUNT, got);
        if (got !== 64'd0) flag_mismatch("REG_COUNT", 64'd0, got);
        // Only the implemented low bits of ADDR and BANK come back
        r = random_word();
        host_write(mem_afu_pkg::REG_ADDR, r);
        host_read(mem_afu_pkg::REG_ADDR, got);
        if (got !== (r & ADDR_MASK)) flag_mismatch("REG_ADDR", r & ADDR_MASK, got);
        r = random_word();
        host_write(mem_afu_pkg::REG_WDATA, r);
        host_read(mem_afu_pkg::REG_WDATA, got);
        if (got !== r) flag_mismatch("REG_WDATA", r, got);
        r = random_word();
        host_write(mem_afu_pkg::REG_BANK, r);
        host_read(mem_afu_pkg::REG_BANK, got);
        if (got !== (r & 64'd1)) flag_mismatch("REG_BANK", r & 64'd1, got);
        host_read(3'd7, got);
        if (got !== 64'd0) flag_mismatch("register 7", 64'd0, got);
        host_write(mem_afu_pkg::REG_BANK, 64'd0);
        log_result("register_access", errs);
    endtask

    task automatic bank0_write_read();
        int errs;
        logic [ADDR_WIDTH-1:0] addrs [8];
        logic [63:0] got;
        errs = error_count;
        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = random_addr();
            write_word(1'b0, addrs[i], random_word());
        end
        // Repeated addresses are fine, the scoreboard keeps the last write
        for (int i = 0; i < 8; i++)
        begin
            read_word(1'b0, addrs[i], got);
            if (got !== expected_mem[0][addrs[i]])
            begin
                flag_mismatch("REG_RDATA", expected_mem[0][addrs[i]], got);
            end
        end
        log_result("bank0_write_read", errs);
    endtask

    task automatic bank_isolation();
        int errs;
        logic [ADDR_WIDTH-1:0] a;
        logic [63:0] got;
        errs = error_count;
        a = random_addr();
        write_word(1'b0, a, random_word());
        write_word(1'b1, a, random_word());
        read_word(1'b0, a, got);
        if (got !== expected_mem[0][a]) flag_mismatch("REG_RDATA bank 0", expected_mem[0][a], got);
        read_word(1'b1, a, got);
        if (got !== expected_mem[1][a]) flag_mismatch("REG_RDATA bank 1", expected_mem[1][a], got);
        // Bank 1 has seen only one write so far, its neighbour is still zero
        read_word(1'b1, a ^ ADDR_WIDTH'(1), got);
        if (got !== 64'd0) flag_mismatch("REG_RDATA unwritten bank 1", 64'd0, got);
        log_result("bank_isolation", errs);
    endtask

    task automatic command_count();
        int errs;
        logic [ADDR_WIDTH-1:0] a;
        logic [63:0] d;
        logic [63:0] got;
        errs = error_count;
        a = random_addr();
        d = random_word();
        // The count covers every access of the earlier tests as well
        host_read(mem_afu_pkg::REG_COUNT, got);
        if (got !== 64'(cmds_done)) flag_mismatch("REG_COUNT", 64'(cmds_done), got);
        write_word(1'b0, a, d);
        host_read(mem_afu_pkg::REG_COUNT, got);
        if (got !== 64'(cmds_done)) flag_mismatch("REG_COUNT", 64'(cmds_done), got);
        read_word(1'b0, a, got);
        if (got !== d) flag_mismatch("REG_RDATA", d, got);
        host_read(mem_afu_pkg::REG_COUNT, got);
        if (got !== 64'(cmds_done)) flag_mismatch("REG_COUNT", 64'(cmds_done), got);
        // NOP and opcode 3 leave both the count and the done flag alone
        host_write(mem_afu_pkg::REG_CMD, 64'(mem_afu_pkg::CMD_NOP));
        host_read(mem_afu_pkg::REG_STATUS, got);
        if (got !== 64'd1) flag_mismatch("REG_STATUS after NOP", 64'd1, got);
        host_write(mem_afu_pkg::REG_CMD, 64'd3);
        host_read(mem_afu_pkg::REG_STATUS, got);
        if (got !== 64'd1) flag_mismatch("REG_STATUS after opcode 3", 64'd1, got);
        host_read(mem_afu_pkg::REG_COUNT, got);
        if (got !== 64'(cmds_done)) flag_mismatch("REG_COUNT after no-ops", 64'(cmds_done), got);
        log_result("command_count", errs);
    endtask

    task automatic busy_protection();
        int errs;
        logic [ADDR_WIDTH-1:0] a;
        logic [63:0] d;
        logic [63:0] got;
        errs = error_count;
        a = random_addr();
        d = random_word();
        write_word(1'b0, a, d);
        host_write(mem_afu_pkg::REG_CMD, 64'(mem_afu_pkg::CMD_READ));
        // Only this first read may complete
        cmds_done++;
        host_read(mem_afu_pkg::REG_STATUS, got);
        if (got[mem_afu_pkg::STATUS_BUSY_BIT] !== 1'b1)
        begin
            flag_mismatch("REG_STATUS busy", 64'd1, 64'(got[mem_afu_pkg::STATUS_BUSY_BIT]));
        end
        // Lands while the first read is still waiting for data
        host_write(mem_afu_pkg::REG_CMD, 64'(mem_afu_pkg::CMD_READ));
        wait_done();
        host_read(mem_afu_pkg::REG_COUNT, got);
        if (got !== 64'(cmds_done)) flag_mismatch("REG_COUNT", 64'(cmds_done), got);
        host_read(mem_afu_pkg::REG_RDATA, got);
        if (got !== d) flag_mismatch("REG_RDATA", d, got);
        host_read(mem_afu_pkg::REG_STATUS, got);
        if (got !== 64'd1) flag_mismatch("REG_STATUS", 64'd1, got);
        log_result("busy_protection", errs);
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        void'($urandom(32'he90b28f3));
        host_req     = '0;
        rst          = 1'b1;
        cmds_done    = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int b = 0; b < 2; b++)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
            begin
                expected_mem[b][i] = 64'd0;
            end
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // Let the retimed reset clear the boundary register
        repeat (2) @(negedge clk);

        register_access();
        bank0_write_read();
        bank_isolation();
        command_count();
        busy_protection();

        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog/host_port_reg.sv
// Host port boundary register

`timescale 1ns/1ns

module host_port_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_afu_pkg::host_req_t host_req,
    input  mem_afu_pkg::host_rsp_t host_rsp_t0,
    output logic                   rst_t1,
    output mem_afu_pkg::host_req_t host_req_t1,
    output mem_afu_pkg::host_rsp_t host_rsp
);

    // Reset is retimed here too, so everything behind the boundary
    // leaves reset on the same edge
    always_ff @(posedge clk)
    begin
        rst_t1 <= rst;
    end

    // Strobes are control, they must not leak out of reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            host_req_t1.wr       <= 1'b0;
            host_req_t1.rd       <= 1'b0;
            host_rsp.rd_valid    <= 1'b0;
        end
        else
        begin
            host_req_t1.wr       <= host_req.wr;
            host_req_t1.rd       <= host_req.rd;
            host_rsp.rd_valid    <= host_rsp_t0.rd_valid;
        end
    end

    // Index and data fields are plain payload and just follow along
    always_ff @(posedge clk)
    begin
        host_req_t1.addr  <= host_req.addr;
        host_req_t1.wdata <= host_req.wdata;
        host_rsp.rdata    <= host_rsp_t0.rdata;
    end

    // The host issues either a write or a read in any one cycle
    a_host_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(host_req.wr && host_req.rd));

endmodule

//--- verilog/mem_afu_pkg.sv
// Memory test accelerator shared types
// Host port, memory port, opcodes and register map

package mem_afu_pkg;

    // ========================================================================
    // Host register port
    // ========================================================================

    // One host access, carried as a single strobe with a word index
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [2:0]  addr;
        logic [63:0] wdata;
    } host_req_t;

    // One host response, rd_valid pulses once per host read
    typedef struct packed {
        logic        rd_valid;
        logic [63:0] rdata;
    } host_rsp_t;

    // ========================================================================
    // Avalon-style local memory port
    // ========================================================================

    // Address is carried at its widest and masked by ADDR_WIDTH in the users
    typedef struct packed {
        logic        read;
        logic        write;
        logic [15:0] address;
        logic [63:0] writedata;
    } mem_req_t;

    typedef struct packed {
        logic        waitrequest;
        logic [63:0] readdata;
        logic        readdatavalid;
    } mem_rsp_t;

    // Command opcodes written to REG_CMD, the unnamed value 3 acts as a no-op
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2
    } mem_cmd_e;

    // Test engine states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_DATA,
        ST_DONE
    } engine_state_e;

    // Register word indices, index 7 is unmapped and reads as zero
    localparam logic [2:0] REG_ADDR   = 3'd0;
    localparam logic [2:0] REG_WDATA  = 3'd1;
    localparam logic [2:0] REG_BANK   = 3'd2;
    localparam logic [2:0] REG_CMD    = 3'd3;
    localparam logic [2:0] REG_STATUS = 3'd4;
    localparam logic [2:0] REG_RDATA  = 3'd5;
    localparam logic [2:0] REG_COUNT  = 3'd6;

    // Bit positions inside the status word
    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_BUSY_BIT = 1;

endpackage

//--- verilog/mem_afu_top.sv
// Memory test accelerator top level

`timescale 1ns/1ns

module mem_afu_top #(
    parameter int ADDR_WIDTH   = 10,
    parameter int READ_LATENCY = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_afu_pkg::host_req_t host_req,
    output mem_afu_pkg::host_rsp_t host_rsp
);

    logic                   rst_t1;
    mem_afu_pkg::host_req_t host_req_t1;
    mem_afu_pkg::host_rsp_t host_rsp_t0;

    // Engine side of the router
    mem_afu_pkg::mem_req_t  mem_req;
    mem_afu_pkg::mem_rsp_t  mem_rsp;
    logic                   bank_sel;

    // Bank side of the router
    mem_afu_pkg::mem_req_t  bank0_req;
    mem_afu_pkg::mem_rsp_t  bank0_rsp;
    mem_afu_pkg::mem_req_t  bank1_req;
    mem_afu_pkg::mem_rsp_t  bank1_rsp;

    // ========================================================================
    // Host boundary and test engine
    // ========================================================================

    host_port_reg host_port_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_rsp_t0 (host_rsp_t0),
        .rst_t1      (rst_t1),
        .host_req_t1 (host_req_t1),
        .host_rsp    (host_rsp)
    );

    mem_test_engine #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) mem_test_engine_inst (
        .clk      (clk),
        .rst      (rst_t1),
        .host_req (host_req_t1),
        .host_rsp (host_rsp_t0),
        .mem_req  (mem_req),
        .bank_sel (bank_sel),
        .mem_rsp  (mem_rsp)
    );

    // ========================================================================
    // Bank routing and local memory
    // ========================================================================

    mem_bank_router mem_bank_router_inst (
        .clk       (clk),
        .rst       (rst_t1),
        .bank_sel  (bank_sel),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .bank0_req (bank0_req),
        .bank0_rsp (bank0_rsp),
        .bank1_req (bank1_req),
        .bank1_rsp (bank1_rsp)
    );

    // Both banks share geometry and latency
    mem_bank_model #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .READ_LATENCY (READ_LATENCY)
    ) mem_bank0_inst (
        .clk (clk),
        .rst (rst_t1),
        .req (bank0_req),
        .rsp (bank0_rsp)
    );

    mem_bank_model #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .READ_LATENCY (READ_LATENCY)
    ) mem_bank1_inst (
        .clk (clk),
        .rst (rst_t1),
        .req (bank1_req),
        .rsp (bank1_rsp)
    );

endmodule

//--- verilog/mem_bank_model.sv
// Behavioural local memory bank

`timescale 1ns/1ns

module mem_bank_model #(
    parameter int ADDR_WIDTH   = 10,
    parameter int READ_LATENCY = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_afu_pkg::mem_req_t req,
    output mem_afu_pkg::mem_rsp_t rsp
);

    localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;

    // Word array starts out all zero
    logic [63:0]           mem_array [MEM_DEPTH] = '{default: '0};

    logic                  wait_seen;
    logic                  req_active;
    logic                  accept;
    logic [ADDR_WIDTH-1:0] word_addr;

    // Read return pipeline, stage READ_LATENCY-1 drives the port
    logic [READ_LATENCY-1:0] valid_pipe;
    logic [63:0]             data_pipe [READ_LATENCY];

    assign req_active = req.read || req.write;
    assign word_addr  = req.address[ADDR_WIDTH-1:0];

    // ========================================================================
    // Request acceptance
    // ========================================================================

    // Every new request is stalled for one cycle, then taken
    assign accept = req_active && wait_seen;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wait_seen <= 1'b0;
        end
        else
        begin
            // Cleared on acceptance so a back-to-back request waits again
            wait_seen <= req_active && !wait_seen;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && req.write)
        begin
            mem_array[word_addr] <= req.writedata;
        end
    end

    // ========================================================================
    // Read return
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe    <= valid_pipe << 1;
            valid_pipe[0] <= accept && req.read;
        end
    end

    // One stage per cycle keeps up to READ_LATENCY reads in flight, in order
    always_ff @(posedge clk)
    begin
        data_pipe[0] <= mem_array[word_addr];
        for (int i = READ_LATENCY - 1; i > 0; i--)
        begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rsp.waitrequest   = req_active && !wait_seen;
    assign rsp.readdatavalid = valid_pipe[READ_LATENCY-1];
    assign rsp.readdata      = data_pipe[READ_LATENCY-1];

endmodule

//--- verilog/mem_bank_router.sv
// Two-bank local memory router

`timescale 1ns/1ns

module mem_bank_router (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bank_sel,
    input  mem_afu_pkg::mem_req_t mem_req,
    output mem_afu_pkg::mem_rsp_t mem_rsp,
    output mem_afu_pkg::mem_req_t bank0_req,
    input  mem_afu_pkg::mem_rsp_t bank0_rsp,
    output mem_afu_pkg::mem_req_t bank1_req,
    input  mem_afu_pkg::mem_rsp_t bank1_rsp
);

    logic [3:0] rd_pending;
    logic       rd_accept;

    // Address and data fan out to both banks, only the strobes are steered
    always_comb
    begin
        bank0_req       = mem_req;
        bank1_req       = mem_req;
        bank0_req.read  = mem_req.read && !bank_sel;
        bank0_req.write = mem_req.write && !bank_sel;
        bank1_req.read  = mem_req.read && bank_sel;
        bank1_req.write = mem_req.write && bank_sel;
    end

    // Waitrequest belongs to the bank that holds the request
    // Read data follows whichever bank is returning, so data still
    // in flight after a bank switch is not dropped
    always_comb
    begin
        mem_rsp.waitrequest   = bank_sel ? bank1_rsp.waitrequest : bank0_rsp.waitrequest;
        mem_rsp.readdatavalid = bank0_rsp.readdatavalid || bank1_rsp.readdatavalid;
        mem_rsp.readdata      = bank1_rsp.readdatavalid ? bank1_rsp.readdata :
                                bank0_rsp.readdata;
    end

    // ========================================================================
    // Outstanding read tracking
    // ========================================================================

    assign rd_accept = mem_req.read && !mem_rsp.waitrequest;

    // Accepted reads not yet returned, an accept and a return can share a cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_pending <= '0;
        end
        else
        begin
            rd_pending <= rd_pending + 4'(rd_accept) - 4'(mem_rsp.readdatavalid);
        end
    end

    // Switching banks with reads pending could reorder the returns
    a_bank_stable: assert property (@(posedge clk) disable iff (rst)
        (rd_pending != 4'd0) |-> $stable(bank_sel));

    a_single_return: assert property (@(posedge clk) disable iff (rst)
        !(bank0_rsp.readdatavalid && bank1_rsp.readdatavalid));

endmodule

//--- verilog/mem_test_engine.sv
// Memory test engine
// Control registers and single-word access FSM

`timescale 1ns/1ns

module mem_test_engine #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_afu_pkg::host_req_t host_req,
    output mem_afu_pkg::host_rsp_t host_rsp,
    output mem_afu_pkg::mem_req_t  mem_req,
    output logic                   bank_sel,
    input  mem_afu_pkg::mem_rsp_t  mem_rsp
);

    mem_afu_pkg::engine_state_e state;
    mem_afu_pkg::mem_cmd_e      cmd_reg;
    mem_afu_pkg::mem_cmd_e      new_cmd;

    logic [ADDR_WIDTH-1:0]      addr_reg;
    logic [63:0]                wdata_reg;
    logic                       bank_reg;
    logic [63:0]                rdata_reg;
    logic [31:0]                count_reg;
    logic                       done_reg;

    logic                       idle;
    logic                       cfg_wr;
    logic                       cmd_start;
    logic [63:0]                rd_mux;

    // ========================================================================
    // Register writes
    // ========================================================================

    assign idle = (state == mem_afu_pkg::ST_IDLE);

    // Host writes only land while idle, which keeps the outstanding
    // request and the bank choice frozen for the length of a command
    assign cfg_wr = host_req.wr && idle;

    // Opcode 3 and CMD_NOP fall through as no-ops
    assign new_cmd   = mem_afu_pkg::mem_cmd_e'(host_req.wdata[1:0]);
    assign cmd_start = cfg_wr && (host_req.addr == mem_afu_pkg::REG_CMD) &&
                       ((new_cmd == mem_afu_pkg::CMD_WRITE) ||
                        (new_cmd == mem_afu_pkg::CMD_READ));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            addr_reg <= '0;
            bank_reg <= 1'b0;
        end
        else if (cfg_wr)
        begin
            // Both registers keep only their implemented low bits
            if (host_req.addr == mem_afu_pkg::REG_ADDR)
            begin
                addr_reg <= host_req.wdata[ADDR_WIDTH-1:0];
            end
            if (host_req.addr == mem_afu_pkg::REG_BANK)
            begin
                bank_reg <= host_req.wdata[0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cfg_wr && (host_req.addr == mem_afu_pkg::REG_WDATA))
        begin
            wdata_reg <= host_req.wdata;
        end
    end

    // ========================================================================
    // Access FSM
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= mem_afu_pkg::ST_IDLE;
            cmd_reg   <= mem_afu_pkg::CMD_NOP;
            done_reg  <= 1'b0;
            count_reg <= '0;
        end
        else
        begin
            case (state)
                mem_afu_pkg::ST_IDLE:
                begin
                    // A fresh command clears the previous done flag
                    if (cmd_start)
                    begin
                        cmd_reg  <= new_cmd;
                        done_reg <= 1'b0;
                        state    <= mem_afu_pkg::ST_ISSUE;
                    end
                end
                mem_afu_pkg::ST_ISSUE:
                begin
                    // The request stays on the port until the bank drops waitrequest
                    if (!mem_rsp.waitrequest)
                    begin
                        if (cmd_reg == mem_afu_pkg::CMD_READ)
                        begin
                            state <= mem_afu_pkg::ST_WAIT_DATA;
                        end
                        else
                        begin
                            state <= mem_afu_pkg::ST_DONE;
                        end
                    end
                end
                mem_afu_pkg::ST_WAIT_DATA:
                begin
                    if (mem_rsp.readdatavalid)
                    begin
                        state <= mem_afu_pkg::ST_DONE;
                    end
                end
                default:
                begin
                    // ST_DONE, done and count update on the way back to idle
                    done_reg  <= 1'b1;
                    count_reg <= count_reg + 32'd1;
                    state     <= mem_afu_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Read data capture, only one read is ever in flight from here
    always_ff @(posedge clk)
    begin
        if ((state == mem_afu_pkg::ST_WAIT_DATA) && mem_rsp.readdatavalid)
        begin
            rdata_reg <= mem_rsp.readdata;
        end
    end

    // Request is decoded straight from the state so it is low in idle
    always_comb
    begin
        mem_req.read      = (state == mem_afu_pkg::ST_ISSUE) &&
                            (cmd_reg == mem_afu_pkg::CMD_READ);
        mem_req.write     = (state == mem_afu_pkg::ST_ISSUE) &&
                            (cmd_reg == mem_afu_pkg::CMD_WRITE);
        mem_req.address   = 16'(addr_reg);
        mem_req.writedata = wdata_reg;
    end

    assign bank_sel = bank_reg;

    // ========================================================================
    // Register reads
    // ========================================================================

    always_comb
    begin
        rd_mux = '0;
        case (host_req.addr)
            mem_afu_pkg::REG_ADDR:   rd_mux = 64'(addr_reg);
            mem_afu_pkg::REG_WDATA:  rd_mux = wdata_reg;
            mem_afu_pkg::REG_BANK:   rd_mux = 64'(bank_reg);
            mem_afu_pkg::REG_STATUS:
            begin
                rd_mux[mem_afu_pkg::STATUS_DONE_BIT] = done_reg;
                rd_mux[mem_afu_pkg::STATUS_BUSY_BIT] = !idle;
            end
            mem_afu_pkg::REG_RDATA:  rd_mux = rdata_reg;
            mem_afu_pkg::REG_COUNT:  rd_mux = 64'(count_reg);
            default:                 rd_mux = '0;
        endcase
    end

    // Each host read is answered exactly one cycle later
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            host_rsp.rd_valid <= 1'b0;
        end
        else
        begin
            host_rsp.rd_valid <= host_req.rd;
        end
    end

    always_ff @(posedge clk)
    begin
        host_rsp.rdata <= rd_mux;
    end

    a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write));

    // Avalon hold rule toward the router and banks
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) && mem_rsp.waitrequest |=> $stable(mem_req));

endmodule
